//--- include/dcache_consts.svh
// Data and strobe widths, byte offset width and misalignment cause codes
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// Data and address width of the memory bus
`define DC_XLEN 64

// One strobe bit per byte lane
`define DC_STRB_W 8

// Byte offset bits inside one bus word
`define DC_OFFSET_W 3

// Exception causes
`define DC_CAUSE_LOAD_MISALIGNED  4'd4
`define DC_CAUSE_STORE_MISALIGNED 4'd6 // Also used for AMOs

`endif

//--- source/dcache_pkg.sv
// Memory op, access size and AMO enums, request, response and write-data structs
`default_nettype none

`include "dcache_consts.svh"

package dcache_pkg;

    typedef enum logic [1:0] {
        MEM_LOAD  = 2'd0,
        MEM_STORE = 2'd1,
        MEM_AMO   = 2'd2
    } mem_op_t;

    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3
    } mem_size_t;

    // Function codes as found in funct7[6:2] of the A extension
    typedef enum logic [4:0] {
        AMO_ADD  = 5'b00000,
        AMO_SWAP = 5'b00001,
        AMO_XOR  = 5'b00100,
        AMO_OR   = 5'b01000,
        AMO_AND  = 5'b01100,
        AMO_MIN  = 5'b10000,
        AMO_MAX  = 5'b10100,
        AMO_MINU = 5'b11000,
        AMO_MAXU = 5'b11100
    } amo_op_t;

    typedef struct packed {
        logic [`DC_XLEN-1:0] addr;
        logic [`DC_XLEN-1:0] value;  // Store data or AMO operand
        mem_op_t             op;
        mem_size_t           size;
        logic                is_unsigned;
        amo_op_t             amo;
    } dcache_req_t;

    typedef struct packed {
        logic [`DC_XLEN-1:0] value;
        logic                exc_valid;
        logic [3:0]          cause;
        logic [`DC_XLEN-1:0] mtval;
    } dcache_resp_t;

    typedef struct packed {
        logic [`DC_XLEN-1:0]   data;
        logic [`DC_STRB_W-1:0] strb;
    } axi_w_t;

endpackage

`default_nettype wire

//--- source/load_aligner.sv
// Load aligner picking a byte, half-word or word lane and extending it
`default_nettype none

`include "dcache_consts.svh"

module load_aligner
    import dcache_pkg::*;
(
    input  wire logic [`DC_XLEN-1:0]     r_data,
    input  wire logic [`DC_OFFSET_W-1:0] offset,
    input  var  mem_size_t               size,
    input  wire logic                    is_unsigned,
    output logic [`DC_XLEN-1:0]          load_value
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic [31:0] word_sel;
    logic        sign_bit;

    // Low offset bits are don't-care for the wider lanes
    assign byte_sel = r_data[{offset, 3'b000} +: 8];
    assign half_sel = r_data[{offset[2:1], 4'b0000} +: 16];
    assign word_sel = r_data[{offset[2], 5'b00000} +: 32];

    always_comb begin
        unique case (size)
            SIZE_B:  sign_bit = byte_sel[7];
            SIZE_H:  sign_bit = half_sel[15];
            default: sign_bit = word_sel[31];
        endcase
    end

    always_comb begin
        unique case (size)
            SIZE_B: begin
                load_value = {{(`DC_XLEN-8){sign_bit & ~is_unsigned}}, byte_sel};
            end
            SIZE_H: begin
                load_value = {{(`DC_XLEN-16){sign_bit & ~is_unsigned}}, half_sel};
            end
            SIZE_W: begin
                load_value = {{(`DC_XLEN-32){sign_bit & ~is_unsigned}}, word_sel};
            end
            default: load_value = r_data; // Full double-word
        endcase
    end

endmodule

`default_nettype wire

//--- source/store_aligner.sv
// Store aligner shifting data into byte lanes and building the write strobe
`default_nettype none

`include "dcache_consts.svh"

module store_aligner
    import dcache_pkg::*;
(
    input  wire logic [`DC_XLEN-1:0]     value,
    input  wire logic [`DC_OFFSET_W-1:0] offset,
    input  var  mem_size_t               size,
    output axi_w_t                       lanes
);

    logic [`DC_STRB_W-1:0] strb;
    logic [`DC_XLEN-1:0]   data;

    assign data = value << {offset, 3'b000};

    always_comb begin
        unique case (size)
            SIZE_B:  strb = 8'b0000_0001 << offset;
            SIZE_H:  strb = 8'b0000_0011 << offset;
            SIZE_W:  strb = 8'b0000_1111 << offset;
            default: strb = 8'b1111_1111;
        endcase
    end

    assign lanes = '{data: data, strb: strb};

endmodule

`default_nettype wire

//--- source/amo_alu.sv
// AMO ALU computing the new memory value for the nine read-modify-write ops
`default_nettype none

`include "dcache_consts.svh"

module amo_alu
    import dcache_pkg::*;
(
    input  wire logic [`DC_XLEN-1:0] original,
    input  wire logic [`DC_XLEN-1:0] operand,
    input  var  mem_size_t           size,
    input  var  amo_op_t             amo,
    output logic [`DC_XLEN-1:0]      amo_result
);

    logic [`DC_XLEN-1:0] a;
    logic [`DC_XLEN-1:0] b;
    logic                signed_lt;
    logic                unsigned_lt;

    // Word ops run on sign-extended halves, which keeps unsigned order too
    assign a = (size == SIZE_W) ? {{32{original[31]}}, original[31:0]} : original;
    assign b = (size == SIZE_W) ? {{32{operand[31]}}, operand[31:0]} : operand;

    assign signed_lt   = $signed(a) < $signed(b);
    assign unsigned_lt = a < b;

    always_comb begin
        unique case (amo)
            AMO_SWAP: amo_result = b;
            AMO_ADD:  amo_result = a + b;
            AMO_XOR:  amo_result = a ^ b;
            AMO_AND:  amo_result = a & b;
            AMO_OR:   amo_result = a | b;
            AMO_MIN:  amo_result = signed_lt ? a : b;
            AMO_MAX:  amo_result = signed_lt ? b : a;
            AMO_MINU: amo_result = unsigned_lt ? a : b;
            AMO_MAXU: amo_result = unsigned_lt ? b : a;
            default:  amo_result = b;
        endcase
    end

endmodule

`default_nettype wire

//--- source/mem_access_fsm.sv
// Access FSM with alignment check, bus channel sequencing and response registers
`default_nettype none

`include "dcache_consts.svh"

module mem_access_fsm
    import dcache_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rstn,

    input  wire logic                req_valid,
    input  var  dcache_req_t         req,
    output logic                     req_ready,
    output logic                     resp_valid,
    output dcache_resp_t             resp,

    output logic                     ar_valid,
    output logic [`DC_XLEN-1:0]      ar_addr,
    input  wire logic                ar_ready,
    input  wire logic                r_valid,
    output logic                     aw_valid,
    output logic [`DC_XLEN-1:0]      aw_addr,
    input  wire logic                aw_ready,
    output logic                     w_valid,
    output axi_w_t                   w,
    input  wire logic                w_ready,
    input  wire logic                b_valid,

    input  wire logic [`DC_XLEN-1:0] load_value,
    input  wire logic [`DC_XLEN-1:0] amo_result,
    input  var  axi_w_t              store_lanes,
    output dcache_req_t              lat_req
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT_R,  // Address on AR, waiting for R
        ST_AMO,     // One ALU cycle
        ST_WAIT_W,  // AW and W issued, waiting for B
        ST_RESP
    } state_t;

    state_t state;
    logic   accept;
    logic   aligned;

    function automatic logic is_aligned(
        input logic [`DC_OFFSET_W-1:0] offset,
        input mem_size_t               size
    );
        unique case (size)
            SIZE_B:  is_aligned = 1'b1;
            SIZE_H:  is_aligned = offset[0] == 1'b0;
            SIZE_W:  is_aligned = offset[1:0] == 2'b00;
            default: is_aligned = offset == 3'b000;
        endcase
    endfunction

    assign req_ready  = state == ST_IDLE;
    assign resp_valid = state == ST_RESP;
    assign accept     = req_valid && req_ready;
    assign aligned    = is_aligned(req.addr[`DC_OFFSET_W-1:0], req.size);

    // Bus payload comes straight from the latched request
    assign ar_addr = lat_req.addr;
    assign aw_addr = lat_req.addr;
    assign w       = store_lanes;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= ST_IDLE;
            ar_valid <= 1'b0;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        if (!aligned) begin
                            state <= ST_RESP; // No bus traffic
                        end else if (req.op == MEM_STORE) begin
                            aw_valid <= 1'b1;
                            w_valid  <= 1'b1;
                            state    <= ST_WAIT_W;
                        end else begin
                            ar_valid <= 1'b1;
                            state    <= ST_WAIT_R;
                        end
                    end
                end
                ST_WAIT_R: begin
                    if (ar_ready) begin
                        ar_valid <= 1'b0;
                    end
                    if (r_valid) begin
                        state <= (lat_req.op == MEM_AMO) ? ST_AMO : ST_RESP;
                    end
                end
                ST_AMO: begin
                    aw_valid <= 1'b1;
                    w_valid  <= 1'b1;
                    state    <= ST_WAIT_W;
                end
                ST_WAIT_W: begin
                    if (aw_ready) begin
                        aw_valid <= 1'b0;
                    end
                    if (w_ready) begin
                        w_valid <= 1'b0;
                    end
                    if (b_valid) begin
                        state <= ST_RESP;
                    end
                end
                default: state <= ST_IDLE; // ST_RESP lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            lat_req             <= req;
            // AMO old values are always sign-extended
            lat_req.is_unsigned <= req.is_unsigned && (req.op == MEM_LOAD);
            resp.value          <= '0; // Stores answer with zero
            resp.exc_valid      <= !aligned;
            resp.cause          <= (req.op == MEM_LOAD) ? `DC_CAUSE_LOAD_MISALIGNED
                                                        : `DC_CAUSE_STORE_MISALIGNED;
            resp.mtval          <= req.addr;
        end
        if (state == ST_WAIT_R && r_valid) begin
            resp.value <= load_value;
        end
        // New memory value replaces the operand, store_aligner then builds its lanes
        if (state == ST_AMO) begin
            lat_req.value <= amo_result;
        end
    end

endmodule

`default_nettype wire

//--- source/dcache_uncached.sv
// Uncached data-memory access unit top with FSM, load/store aligners and AMO ALU
`default_nettype none

`include "dcache_consts.svh"

module dcache_uncached
    import dcache_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rstn,

    input  wire logic                req_valid,
    input  var  dcache_req_t         req,
    output logic                     req_ready,
    output logic                     resp_valid,
    output dcache_resp_t             resp,

    output logic                     ar_valid,
    output logic [`DC_XLEN-1:0]      ar_addr,
    input  wire logic                ar_ready,
    input  wire logic                r_valid,
    input  wire logic [`DC_XLEN-1:0] r_data,
    output logic                     aw_valid,
    output logic [`DC_XLEN-1:0]      aw_addr,
    input  wire logic                aw_ready,
    output logic                     w_valid,
    output axi_w_t                   w,
    input  wire logic                w_ready,
    input  wire logic                b_valid
);

    dcache_req_t         lat_req;
    logic [`DC_XLEN-1:0] load_value;
    logic [`DC_XLEN-1:0] amo_result;
    axi_w_t              store_lanes;

    mem_access_fsm u_fsm (
        .clk         (clk),
        .rstn        (rstn),
        .req_valid   (req_valid),
        .req         (req),
        .req_ready   (req_ready),
        .resp_valid  (resp_valid),
        .resp        (resp),
        .ar_valid    (ar_valid),
        .ar_addr     (ar_addr),
        .ar_ready    (ar_ready),
        .r_valid     (r_valid),
        .aw_valid    (aw_valid),
        .aw_addr     (aw_addr),
        .aw_ready    (aw_ready),
        .w_valid     (w_valid),
        .w           (w),
        .w_ready     (w_ready),
        .b_valid     (b_valid),
        .load_value  (load_value),
        .amo_result  (amo_result),
        .store_lanes (store_lanes),
        .lat_req     (lat_req)
    );

    load_aligner u_load_aligner (
        .r_data      (r_data),
        .offset      (lat_req.addr[`DC_OFFSET_W-1:0]),
        .size        (lat_req.size),
        .is_unsigned (lat_req.is_unsigned),
        .load_value  (load_value)
    );

    // Original is the registered old value held in the response
    amo_alu u_amo_alu (
        .original   (resp.value),
        .operand    (lat_req.value),
        .size       (lat_req.size),
        .amo        (lat_req.amo),
        .amo_result (amo_result)
    );

    // Carries the AMO result once the FSM has written it back into lat_req
    store_aligner u_store_aligner (
        .value  (lat_req.value),
        .offset (lat_req.addr[`DC_OFFSET_W-1:0]),
        .size   (lat_req.size),
        .lanes  (store_lanes)
    );

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
// Testbench clock and reset generator
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 unit period
    end

    initial begin
        rstn = 1'b0;
        repeat (5) @(posedge clk);
        #1 rstn = 1'b1;
    end

endmodule

`default_nettype wire

//--- tests/dcache_sva.sv
// Bound assertions on bus channel handshakes, response pulse and request gating
`default_nettype none

`include "dcache_consts.svh"

module dcache_sva
    import dcache_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rstn,
    input  wire logic                req_ready,
    input  wire logic                resp_valid,
    input  wire logic                ar_valid,
    input  wire logic                ar_ready,
    input  wire logic [`DC_XLEN-1:0] ar_addr,
    input  wire logic                aw_valid,
    input  wire logic                aw_ready,
    input  wire logic [`DC_XLEN-1:0] aw_addr,
    input  wire logic                w_valid,
    input  wire logic                w_ready,
    input  var  axi_w_t              w
);

    ar_hold: assert property (@(posedge clk) disable iff (!rstn)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
        else $error("ar_valid dropped or ar_addr changed before ar_ready");

    aw_hold: assert property (@(posedge clk) disable iff (!rstn)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr))
        else $error("aw_valid dropped or aw_addr changed before aw_ready");

    w_hold: assert property (@(posedge clk) disable iff (!rstn)
        w_valid && !w_ready |=> w_valid && $stable(w.data) && $stable(w.strb))
        else $error("w_valid dropped or write payload changed before w_ready");

    // Response is a single cycle pulse
    resp_pulse: assert property (@(posedge clk) disable iff (!rstn)
        resp_valid |=> !resp_valid)
        else $error("resp_valid held longer than one cycle");

    busy_gate: assert property (@(posedge clk) disable iff (!rstn)
        (ar_valid || aw_valid || w_valid) |-> !req_ready)
        else $error("req_ready high while a bus valid is high");

endmodule

bind dcache_uncached dcache_sva u_sva (
    .clk        (clk),
    .rstn       (rstn),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .ar_valid   (ar_valid),
    .ar_ready   (ar_ready),
    .ar_addr    (ar_addr),
    .aw_valid   (aw_valid),
    .aw_ready   (aw_ready),
    .aw_addr    (aw_addr),
    .w_valid    (w_valid),
    .w_ready    (w_ready),
    .w          (w)
);

`default_nettype wire

//--- tests/tb_dcache.sv
// Testbench top with bus memory model, reference model, stimulus, checks and timeout
`default_nettype none

`include "dcache_consts.svh"

module tb_dcache
    import dcache_pkg::*;
();

    localparam int MAX_CYCLES = 20000; // About 400 requests at up to 50 cycles

    logic                clk;
    logic                rstn;
    logic                req_valid;
    dcache_req_t         req;
    logic                req_ready;
    logic                resp_valid;
    dcache_resp_t        resp;
    logic                ar_valid;
    logic [`DC_XLEN-1:0] ar_addr;
    logic                ar_ready;
    logic                r_valid;
    logic [`DC_XLEN-1:0] r_data;
    logic                aw_valid;
    logic [`DC_XLEN-1:0] aw_addr;
    logic                aw_ready;
    logic                w_valid;
    axi_w_t              w;
    logic                w_ready;
    logic                b_valid;

    logic [63:0]  mem [0:31];
    logic [63:0]  shadow [0:31];
    integer       seed = 84224;
    int           errors = 0;
    int           cycles = 0;
    int           n_reads = 0;
    int           n_writes = 0;
    int           n_resp = 0;

    // Expected outcome of the request in flight
    logic         pending = 1'b0;
    dcache_resp_t exp_resp;
    logic [63:0]  exp_word;
    logic [63:0]  exp_addr;
    logic [4:0]   exp_idx;
    int           exp_reads;
    int           exp_writes;
    int           rd_base;
    int           wr_base;

    amo_op_t amo_list [9] = '{AMO_SWAP, AMO_ADD, AMO_XOR, AMO_AND, AMO_OR,
                              AMO_MIN, AMO_MAX, AMO_MINU, AMO_MAXU};

    tb_clk_gen u_clk_gen (
        .clk  (clk),
        .rstn (rstn)
    );

    dcache_uncached u_dut (
        .clk        (clk),
        .rstn       (rstn),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp       (resp),
        .ar_valid   (ar_valid),
        .ar_addr    (ar_addr),
        .ar_ready   (ar_ready),
        .r_valid    (r_valid),
        .r_data     (r_data),
        .aw_valid   (aw_valid),
        .aw_addr    (aw_addr),
        .aw_ready   (aw_ready),
        .w_valid    (w_valid),
        .w          (w),
        .w_ready    (w_ready),
        .b_valid    (b_valid)
    );

    function automatic logic [63:0] extend_value(input logic [63:0] v, input int nb,
                                                 input bit sext);
        logic [63:0] mask;
        mask = (64'd1 << (8 * nb)) - 64'd1; // All ones for a double-word
        extend_value = (v & mask) | ((sext && v[8 * nb - 1]) ? ~mask : 64'd0);
    endfunction

    function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] val,
                                                input int off, input int nb);
        logic [63:0] nw;
        nw = old;
        for (int i = 0; i < 8; i++) begin
            if (i >= off && i < off + nb) begin
                nw[8 * i +: 8] = val[8 * (i - off) +: 8];
            end
        end
        merge_bytes = nw;
    endfunction

    function automatic logic [63:0] amo_calc(input amo_op_t op, input logic [63:0] a,
                                             input logic [63:0] b);
        case (op)
            AMO_SWAP: amo_calc = b;
            AMO_ADD:  amo_calc = a + b;
            AMO_XOR:  amo_calc = a ^ b;
            AMO_AND:  amo_calc = a & b;
            AMO_OR:   amo_calc = a | b;
            AMO_MIN:  amo_calc = ($signed(a) < $signed(b)) ? a : b;
            AMO_MAX:  amo_calc = ($signed(a) < $signed(b)) ? b : a;
            AMO_MINU: amo_calc = (a < b) ? a : b;
            default:  amo_calc = (a < b) ? b : a; // maxu
        endcase
    endfunction

    // Expected response and memory word for one request
    function automatic void ref_model(input dcache_req_t r, input logic [63:0] old,
                                      output dcache_resp_t e, output logic [63:0] nw);
        int          off;
        int          nb;
        logic [63:0] lane;
        logic [63:0] a;
        logic [63:0] b;
        off  = int'(r.addr[2:0]);
        nb   = 1 << int'(r.size);
        e    = '0;
        nw   = old;
        lane = old >> (8 * off);
        if ((off % nb) != 0) begin
            e.exc_valid = 1'b1;
            e.cause     = (r.op == MEM_LOAD) ? `DC_CAUSE_LOAD_MISALIGNED
                                             : `DC_CAUSE_STORE_MISALIGNED;
            e.mtval     = r.addr;
        end else if (r.op == MEM_LOAD) begin
            e.value = extend_value(lane, nb, !r.is_unsigned);
        end else if (r.op == MEM_STORE) begin
            nw = merge_bytes(old, r.value, off, nb);
        end else begin
            a       = extend_value(lane, nb, 1'b1);
            b       = (nb == 4) ? extend_value(r.value, 4, 1'b1) : r.value; // Word ops only
            e.value = a;
            nw      = merge_bytes(old, amo_calc(r.amo, a, b), off, nb);
        end
    endfunction

    function automatic dcache_req_t make_req(input mem_op_t op, input int size, input int idx,
                                             input int off, input bit uns,
                                             input logic [63:0] value, input amo_op_t amo);
        dcache_req_t r;
        r.addr        = 64'h8000_0000 + {56'd0, 5'(idx), 3'(off)};
        r.value       = value;
        r.op          = op;
        r.size        = mem_size_t'(size);
        r.is_unsigned = uns;
        r.amo         = amo;
        make_req = r;
    endfunction

    function automatic logic [63:0] pick_operand();
        case ($random(seed) & 7)
            0:       pick_operand = 64'd0;
            1:       pick_operand = 64'd1;
            2:       pick_operand = 64'hffff_ffff_ffff_ffff;
            3:       pick_operand = 64'h0000_0000_7fff_ffff;
            4:       pick_operand = 64'h0000_0000_8000_0000;
            5:       pick_operand = 64'h7fff_ffff_ffff_ffff;
            6:       pick_operand = 64'h8000_0000_0000_0000;
            default: pick_operand = {$random(seed), $random(seed)};
        endcase
    endfunction

    // Issue one request and wait for its response, starting just after a rising edge
    task automatic issue(input dcache_req_t r);
        int done;
        ref_model(r, shadow[r.addr[7:3]], exp_resp, exp_word);
        exp_addr   = r.addr;
        exp_idx    = r.addr[7:3];
        exp_reads  = (!exp_resp.exc_valid && r.op != MEM_STORE) ? 1 : 0;
        exp_writes = (!exp_resp.exc_valid && r.op != MEM_LOAD) ? 1 : 0;
        rd_base    = n_reads;
        wr_base    = n_writes;
        done       = n_resp;
        pending    = 1'b1;
        req        = r;
        req_valid  = 1'b1;
        do @(negedge clk); while (!req_ready);
        @(posedge clk);
        #1 req_valid = 1'b0;
        while (n_resp == done) @(posedge clk);
        #1;
    endtask

    // Compare process
    always @(negedge clk) begin
        if (rstn) begin
            if (pending && exp_resp.exc_valid && (ar_valid || aw_valid || w_valid)) begin
                $display("Bus valid raised for a misaligned request");
                errors++;
            end
            if (pending && ar_valid && ar_addr !== exp_addr) begin
                $display("FAILED ar_addr expected %h actual %h", exp_addr, ar_addr);
                errors++;
            end
            if (pending && aw_valid && aw_addr !== exp_addr) begin
                $display("FAILED aw_addr expected %h actual %h", exp_addr, aw_addr);
                errors++;
            end
            if (resp_valid && !pending) begin
                $display("Response received with no request outstanding");
                errors++;
            end else if (resp_valid) begin
                if (resp.exc_valid !== exp_resp.exc_valid) begin
                    $display("FAILED resp.exc_valid expected %h actual %h",
                             exp_resp.exc_valid, resp.exc_valid);
                    errors++;
                end
                if (exp_resp.exc_valid && resp.cause !== exp_resp.cause) begin
                    $display("FAILED resp.cause expected %h actual %h",
                             exp_resp.cause, resp.cause);
                    errors++;
                end
                if (exp_resp.exc_valid && resp.mtval !== exp_resp.mtval) begin
                    $display("FAILED resp.mtval expected %h actual %h",
                             exp_resp.mtval, resp.mtval);
                    errors++;
                end
                if (resp.value !== exp_resp.value) begin
                    $display("FAILED resp.value expected %h actual %h",
                             exp_resp.value, resp.value);
                    errors++;
                end
                if (mem[exp_idx] !== exp_word) begin
                    $display("FAILED mem word expected %h actual %h", exp_word, mem[exp_idx]);
                    errors++;
                end
                if (n_reads - rd_base != exp_reads || n_writes - wr_base != exp_writes) begin
                    $display("Wrong number of bus transfers for one request");
                    errors++;
                end
                shadow[exp_idx] = exp_word;
                pending = 1'b0;
                n_resp++;
            end
        end
    end

    // Memory model with random ready and response delays
    initial begin
        logic       ar_hs;
        logic       aw_hs;
        logic       w_hs;
        logic       ar_hold;
        logic       aw_hold;
        logic       w_hold;
        logic [4:0] ar_idx;
        logic [4:0] aw_idx;
        axi_w_t     w_s;
        logic       rd_busy;
        logic       b_busy;
        logic       aw_got;
        logic       w_got;
        logic [4:0] rd_idx;
        logic [4:0] wr_idx;
        axi_w_t     wr_lanes;
        int         rd_delay;
        int         b_delay;
        int         ar_wait;
        int         aw_wait;
        int         w_wait;
        rd_busy  = 1'b0;
        b_busy   = 1'b0;
        aw_got   = 1'b0;
        w_got    = 1'b0;
        rd_idx   = '0;
        wr_idx   = '0;
        wr_lanes = '0;
        rd_delay = 0;
        b_delay  = 0;
        ar_wait  = 0;
        aw_wait  = 0;
        w_wait   = 0;
        forever begin
            @(negedge clk);
            ar_hs   = ar_valid && ar_ready;
            aw_hs   = aw_valid && aw_ready;
            w_hs    = w_valid && w_ready;
            ar_hold = ar_valid && !ar_ready;
            aw_hold = aw_valid && !aw_ready;
            w_hold  = w_valid && !w_ready;
            ar_idx  = ar_addr[7:3];
            aw_idx  = aw_addr[7:3];
            w_s     = w;
            @(posedge clk);
            #1;
            r_valid = 1'b0;
            b_valid = 1'b0;
            if (ar_hs) begin
                rd_busy  = 1'b1;
                rd_idx   = ar_idx;
                rd_delay = $random(seed) & 3;
                n_reads++;
            end
            if (rd_busy) begin
                if (rd_delay == 0) begin
                    r_valid = 1'b1;
                    r_data  = mem[rd_idx];
                    rd_busy = 1'b0;
                end else begin
                    rd_delay--;
                end
            end
            if (aw_hs) begin
                aw_got = 1'b1;
                wr_idx = aw_idx;
            end
            if (w_hs) begin
                w_got    = 1'b1;
                wr_lanes = w_s;
            end
            if (aw_got && w_got && !b_busy) begin
                b_busy  = 1'b1;
                b_delay = $random(seed) & 3;
                aw_got  = 1'b0;
                w_got   = 1'b0;
            end
            if (b_busy) begin
                if (b_delay == 0) begin
                    b_valid = 1'b1;
                    for (int i = 0; i < 8; i++) begin
                        if (wr_lanes.strb[i]) begin
                            mem[wr_idx][8 * i +: 8] = wr_lanes.data[8 * i +: 8];
                        end
                    end
                    n_writes++;
                    b_busy = 1'b0;
                end else begin
                    b_delay--;
                end
            end
            ar_wait  = ar_hold ? ar_wait + 1 : 0;
            aw_wait  = aw_hold ? aw_wait + 1 : 0;
            w_wait   = w_hold ? w_wait + 1 : 0;
            ar_ready = (ar_wait >= 3) || (($random(seed) & 1) != 0); // At most 3 wait cycles
            aw_ready = (aw_wait >= 3) || (($random(seed) & 1) != 0);
            w_ready  = (w_wait >= 3) || (($random(seed) & 1) != 0);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, a request never completed", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        int          nb;
        int          op_sel;
        int          sz;
        int          off;
        dcache_req_t r;
        req_valid = 1'b0;
        req       = '0;
        ar_ready  = 1'b0;
        r_valid   = 1'b0;
        r_data    = '0;
        aw_ready  = 1'b0;
        w_ready   = 1'b0;
        b_valid   = 1'b0;
        for (int i = 0; i < 32; i++) begin
            mem[i]    = {32'h9e37_79b9 * (i + 1), ~(32'h0101_0101 * i)}; // Varies with all index bits
            shadow[i] = mem[i];
        end
        @(posedge rstn);
        @(posedge clk);
        #1;

        // Aligned loads
        for (int s = 0; s < 4; s++) begin
            nb = 1 << s;
            for (int o = 0; o < 8; o += nb) begin
                for (int u = 0; u < 2; u++) begin
                    issue(make_req(MEM_LOAD, s, $random(seed) & 31, o, u[0], 64'd0, AMO_ADD));
                end
            end
        end

        // Aligned stores, each read back as a double-word
        for (int s = 0; s < 4; s++) begin
            nb = 1 << s;
            for (int o = 0; o < 8; o += nb) begin
                r = make_req(MEM_STORE, s, $random(seed) & 31, o, 1'b0,
                             {$random(seed), $random(seed)}, AMO_ADD);
                issue(r);
                issue(make_req(MEM_LOAD, 3, r.addr[7:3], 0, 1'b0, 64'd0, AMO_ADD));
            end
        end

        // Misaligned loads, stores and AMOs
        for (int p = 0; p < 3; p++) begin
            for (int s = 1; s < 4; s++) begin
                nb = 1 << s;
                for (int o = 1; o < 8; o++) begin
                    if ((o % nb) != 0) begin
                        issue(make_req(mem_op_t'(p), s, $random(seed) & 31, o, 1'b0,
                                       pick_operand(), AMO_SWAP));
                    end
                end
            end
        end

        // AMOs at word and double-word size
        for (int k = 0; k < 9; k++) begin
            for (int s = 2; s < 4; s++) begin
                for (int n = 0; n < 4; n++) begin
                    off = (s == 2) ? (($random(seed) & 1) * 4) : 0;
                    issue(make_req(MEM_AMO, s, $random(seed) & 31, off, 1'b0,
                                   pick_operand(), amo_list[k]));
                end
            end
        end

        // Random mix under back-pressure
        for (int n = 0; n < 200; n++) begin
            op_sel = $random(seed) & 3;
            sz     = $random(seed) & 3;
            nb     = 1 << sz;
            off    = $random(seed) & 7;
            if (($random(seed) & 7) != 0) begin
                off = off - (off % nb); // Mostly aligned
            end
            r = make_req((op_sel == 3) ? MEM_LOAD : mem_op_t'(op_sel), sz, $random(seed) & 31,
                         off, (op_sel != 2) && (($random(seed) & 1) != 0), pick_operand(),
                         amo_list[($random(seed) & 32'h7fff_ffff) % 9]);
            issue(r);
        end

        repeat (3) @(posedge clk);
        $display("Errors: %0d, responses: %0d", errors, n_resp);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dcache_uncached.f
+incdir+include
source/dcache_pkg.sv
source/load_aligner.sv
source/store_aligner.sv
source/amo_alu.sv
source/mem_access_fsm.sv
source/dcache_uncached.sv
tests/tb_clk_gen.sv
tests/dcache_sva.sv
tests/tb_dcache.sv

//--- run.sh
#!/bin/bash
# Build and run the dcache_uncached testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f dcache_uncached.f --top-module tb_dcache -o sim_dcache
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_dcache)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
